/* verilog/soc_bus_pkg.sv */
/*
 * bus transaction types and the address map of the peripheral subsystem.
 * addresses are word addresses, so byte bits 1:0 never appear on the bus.
 * every access is a full 32-bit word and there are no byte enables.
 */

package soc_bus_pkg;

	// ------------------------------------------------------------
	// bus widths
	// ------------------------------------------------------------
	localparam int BUS_ADDR_WIDTH = 30;
	localparam int BUS_DATA_WIDTH = 32;

	// top address byte selects the slave
	localparam int MAP_MSB = 29;
	localparam int MAP_LSB = 22;

	localparam logic [7:0] MAP_ROM   = 8'h00;
	localparam logic [7:0] MAP_IRC   = 8'hF0;
	localparam logic [7:0] MAP_TIMER = 8'hF1;

	// boot rom holds 2**ROM_ADDR_WIDTH words
	localparam int ROM_ADDR_WIDTH = 4;

	// ------------------------------------------------------------
	// transaction types
	// ------------------------------------------------------------
	typedef struct packed {
		logic [BUS_ADDR_WIDTH-1:0] addr;
		logic                      we;
		logic [BUS_DATA_WIDTH-1:0] wdata;
	} bus_cmd_t;

	typedef struct packed {
		logic [BUS_DATA_WIDTH-1:0] rdata;
	} bus_rsp_t;

endpackage

/* verilog/soc_periph_pkg.sv */
/*
 * register offsets and sizes of the interrupt controller, timer and rom.
 * offsets are word offsets taken from address bits 1:0 of each slave.
 * interrupt factor 0 is the timer, factors 1 and 2 are the external lines.
 */

package soc_periph_pkg;

	// ------------------------------------------------------------
	// interrupt controller
	// ------------------------------------------------------------
	localparam int IRQ_NUM      = 3;
	localparam int IRQ_ID_WIDTH = 2;
	localparam int PRIO_WIDTH   = 2;

	localparam logic [1:0] IRC_REG_ENABLE = 2'd0;
	localparam logic [1:0] IRC_REG_PRIO   = 2'd1;
	localparam logic [1:0] IRC_REG_MASK   = 2'd2;
	localparam logic [1:0] IRC_REG_ACTIVE = 2'd3;

	// ------------------------------------------------------------
	// timer
	// ------------------------------------------------------------
	localparam logic [1:0] TIMER_REG_CTRL    = 2'd0;
	localparam logic [1:0] TIMER_REG_COMPARE = 2'd1;
	localparam logic [1:0] TIMER_REG_COUNTER = 2'd2;
	localparam logic [1:0] TIMER_REG_STATUS  = 2'd3;

	// ------------------------------------------------------------
	// boot rom
	// ------------------------------------------------------------
	localparam int ROM_DEPTH = 1 << soc_bus_pkg::ROM_ADDR_WIDTH;

endpackage

/* verilog/soc_addr_decoder.sv */
/*
 * routes a four-phase bus transaction to one slave by the top address byte.
 * cmd must stay stable until ack falls, since the response mux follows it.
 * unmapped addresses complete after one clock with zero read data.
 */

`timescale 1ns/1ps

module soc_addr_decoder (
	input  logic                  clk,
	input  logic                  reset,

	// bus from the master
	input  logic                  bus_req_i,
	input  soc_bus_pkg::bus_cmd_t bus_cmd_i,
	output logic                  bus_ack_o,
	output soc_bus_pkg::bus_rsp_t bus_rsp_o,

	// slaves
	output logic                  rom_req_o,
	input  logic                  rom_ack_i,
	input  soc_bus_pkg::bus_rsp_t rom_rsp_i,

	output logic                  irc_req_o,
	input  logic                  irc_ack_i,
	input  soc_bus_pkg::bus_rsp_t irc_rsp_i,

	output logic                  tmr_req_o,
	input  logic                  tmr_ack_i,
	input  soc_bus_pkg::bus_rsp_t tmr_rsp_i
);
	import soc_bus_pkg::*;

	logic [7:0] sel_byte;
	logic       unm_sel;
	logic       unm_ack;

	assign sel_byte = bus_cmd_i.addr[MAP_MSB:MAP_LSB];

	// ------------------------------------------------------------
	// request routing and response mux
	// ------------------------------------------------------------
	always_comb begin
		rom_req_o = 1'b0;
		irc_req_o = 1'b0;
		tmr_req_o = 1'b0;
		unm_sel   = 1'b0;
		bus_ack_o = 1'b0;
		bus_rsp_o = '0;

		case (sel_byte)
			MAP_ROM: begin
				rom_req_o = bus_req_i;
				bus_ack_o = rom_ack_i;
				bus_rsp_o = rom_rsp_i;
			end
			MAP_IRC: begin
				irc_req_o = bus_req_i;
				bus_ack_o = irc_ack_i;
				bus_rsp_o = irc_rsp_i;
			end
			MAP_TIMER: begin
				tmr_req_o = bus_req_i;
				bus_ack_o = tmr_ack_i;
				bus_rsp_o = tmr_rsp_i;
			end
			default: begin
				// nobody home, data stays zero
				unm_sel   = 1'b1;
				bus_ack_o = unm_ack;
			end
		endcase
	end

	// ack follows req one edge later, same as the slaves
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			unm_ack <= 1'b0;
		end else begin
			unm_ack <= bus_req_i & unm_sel;
		end
	end

endmodule

/* verilog/soc_boot_rom.sv */
/*
 * read-only word memory, contents loaded from boot_rom.hex at start.
 * only the low address bits index the array, so higher addresses wrap.
 * writes complete their handshake and are discarded.
 */

`timescale 1ns/1ps

module soc_boot_rom (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  req_i,
	input  soc_bus_pkg::bus_cmd_t cmd_i,
	output logic                  ack_o,
	output soc_bus_pkg::bus_rsp_t rsp_o
);
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;

	logic [BUS_DATA_WIDTH-1:0] mem [ROM_DEPTH];
	logic [BUS_DATA_WIDTH-1:0] rdata_q;
	logic                      ack_q;
	logic [ROM_ADDR_WIDTH-1:0] word_idx;

	initial begin
		$readmemh("boot_rom.hex", mem);
	end

	assign word_idx = cmd_i.addr[ROM_ADDR_WIDTH-1:0];

	// handshake
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req_i;
		end
	end

	// data is captured on the edge that raises ack
	always_ff @(posedge clk) begin
		if (req_i && !ack_q) begin
			rdata_q <= mem[word_idx];
		end
	end

	assign ack_o       = ack_q;
	assign rsp_o.rdata = rdata_q;

endmodule

/* verilog/soc_irc.sv */
/*
 * priority interrupt controller with ENABLE, PRIO, MASK and ACTIVE words.
 * higher PRIO value wins, ties go to the lower factor index.
 * a request that loses all eligible factors before the cpu acknowledges
 * is dropped without setting the active flag.
 */

`timescale 1ns/1ps

module soc_irc (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                req_i,
	input  soc_bus_pkg::bus_cmd_t               cmd_i,
	output logic                                ack_o,
	output soc_bus_pkg::bus_rsp_t               rsp_o,
	input  logic [soc_periph_pkg::IRQ_NUM-1:0] irq_i,
	output logic                                cpu_irq_o,
	input  logic                                cpu_irq_ack_i
);
	import soc_periph_pkg::*;

	logic [IRQ_NUM-1:0]            enable_q;
	logic [IRQ_NUM*PRIO_WIDTH-1:0] prio_q;
	logic [PRIO_WIDTH-1:0]         mask_q;
	logic [IRQ_ID_WIDTH-1:0]       active_id_q;
	logic                          active_q;
	logic                          ack_q;
	logic                          irq_q;
	logic [31:0]                   rdata_q;
	logic [1:0]                    reg_sel;
	logic                          bus_go;
	logic [PRIO_WIDTH-1:0]         active_prio;
	logic                          found;
	logic [IRQ_ID_WIDTH-1:0]       win_id;
	logic [PRIO_WIDTH-1:0]         win_prio;

	assign reg_sel = cmd_i.addr[1:0];
	assign bus_go  = req_i & ~ack_q;

	// ------------------------------------------------------------
	// arbitration
	// ------------------------------------------------------------
	always_comb begin
		active_prio = '0;
		found       = 1'b0;
		win_id      = '0;
		win_prio    = '0;
		for (int i = 0; i < IRQ_NUM; i++) begin
			if (active_id_q == IRQ_ID_WIDTH'(i)) begin
				active_prio = prio_q[i*PRIO_WIDTH +: PRIO_WIDTH];
			end
		end
		// strict compare keeps the lowest index on a tie
		for (int i = 0; i < IRQ_NUM; i++) begin
			if (irq_i[i] && enable_q[i]
					&& prio_q[i*PRIO_WIDTH +: PRIO_WIDTH] > mask_q
					&& (!active_q || prio_q[i*PRIO_WIDTH +: PRIO_WIDTH] > active_prio)
					&& (!found || prio_q[i*PRIO_WIDTH +: PRIO_WIDTH] > win_prio)) begin
				found    = 1'b1;
				win_id   = IRQ_ID_WIDTH'(i);
				win_prio = prio_q[i*PRIO_WIDTH +: PRIO_WIDTH];
			end
		end
	end

	// ------------------------------------------------------------
	// registers and cpu handshake
	// ------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack_q       <= 1'b0;
			irq_q       <= 1'b0;
			enable_q    <= '0;
			prio_q      <= '0;
			mask_q      <= '0;
			active_id_q <= '0;
			active_q    <= 1'b0;
		end else begin
			ack_q <= req_i;
			if (bus_go && cmd_i.we) begin
				case (reg_sel)
					IRC_REG_ENABLE: enable_q <= cmd_i.wdata[IRQ_NUM-1:0];
					IRC_REG_PRIO:   prio_q   <= cmd_i.wdata[IRQ_NUM*PRIO_WIDTH-1:0];
					IRC_REG_MASK:   mask_q   <= cmd_i.wdata[PRIO_WIDTH-1:0];
					default:        active_q <= 1'b0;
				endcase
			end

			// cpu ack takes precedence over a same-cycle ACTIVE write
			if (irq_q) begin
				if (cpu_irq_ack_i) begin
					irq_q <= 1'b0;
					if (found) begin
						active_id_q <= win_id;
						active_q    <= 1'b1;
					end
				end
			end else if (found && !cpu_irq_ack_i) begin
				irq_q <= 1'b1;
			end
		end
	end

	// read data
	always_ff @(posedge clk) begin
		if (bus_go) begin
			case (reg_sel)
				IRC_REG_ENABLE: rdata_q <= 32'(enable_q);
				IRC_REG_PRIO:   rdata_q <= 32'(prio_q);
				IRC_REG_MASK:   rdata_q <= 32'(mask_q);
				default: begin
					rdata_q <= {23'd0, active_q, {(8-IRQ_ID_WIDTH){1'b0}}, active_id_q};
				end
			endcase
		end
	end

	assign ack_o       = ack_q;
	assign rsp_o.rdata = rdata_q;
	assign cpu_irq_o   = irq_q;

endmodule

/* verilog/soc_timer.sv */
/*
 * free-running compare timer. the counter wraps to zero on reaching COMPARE
 * and sets the expiry flag, which stays until software writes 1 to STATUS.
 * a bus write to COUNTER overrides the count step on the same edge.
 */

`timescale 1ns/1ps

module soc_timer (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  req_i,
	input  soc_bus_pkg::bus_cmd_t cmd_i,
	output logic                  ack_o,
	output soc_bus_pkg::bus_rsp_t rsp_o,
	output logic                  irq_o
);
	import soc_periph_pkg::*;

	logic [1:0]  ctrl_q;
	logic [31:0] compare_q;
	logic [31:0] counter_q;
	logic        expired_q;
	logic        ack_q;
	logic [31:0] rdata_q;
	logic [1:0]  reg_sel;
	logic        bus_go;
	logic        bus_wr;

	assign reg_sel = cmd_i.addr[1:0];
	assign bus_go  = req_i & ~ack_q;
	assign bus_wr  = bus_go & cmd_i.we;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack_q     <= 1'b0;
			ctrl_q    <= '0;
			compare_q <= '0;
			counter_q <= '0;
			expired_q <= 1'b0;
		end else begin
			ack_q <= req_i;
			if (bus_wr && reg_sel == TIMER_REG_CTRL) begin
				ctrl_q <= cmd_i.wdata[1:0];
			end
			if (bus_wr && reg_sel == TIMER_REG_COMPARE) begin
				compare_q <= cmd_i.wdata;
			end
			if (bus_wr && reg_sel == TIMER_REG_STATUS && cmd_i.wdata[0]) begin
				expired_q <= 1'b0;
			end

			// count, a new expiry wins over a clear
			if (bus_wr && reg_sel == TIMER_REG_COUNTER) begin
				counter_q <= cmd_i.wdata;
			end else if (ctrl_q[0]) begin
				if (counter_q == compare_q) begin
					counter_q <= '0;
					expired_q <= 1'b1;
				end else begin
					counter_q <= counter_q + 32'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus_go) begin
			case (reg_sel)
				TIMER_REG_CTRL:    rdata_q <= 32'(ctrl_q);
				TIMER_REG_COMPARE: rdata_q <= compare_q;
				TIMER_REG_COUNTER: rdata_q <= counter_q;
				default:           rdata_q <= 32'(expired_q);
			endcase
		end
	end

	assign ack_o       = ack_q;
	assign rsp_o.rdata = rdata_q;
	assign irq_o       = expired_q & ctrl_q[1];

endmodule

/* verilog/soc_periph_top.sv */
/*
 * peripheral subsystem: decoder, boot rom, interrupt controller and timer.
 * bus and cpu interrupt both use a four-phase req/ack handshake.
 */

`timescale 1ns/1ps

module soc_periph_top (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  bus_req_i,
	input  soc_bus_pkg::bus_cmd_t bus_cmd_i,
	output logic                  bus_ack_o,
	output soc_bus_pkg::bus_rsp_t bus_rsp_o,
	input  logic [1:0]            irq_ext_i,
	output logic                  cpu_irq_o,
	input  logic                  cpu_irq_ack_i
);
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;

	logic         rom_req, rom_ack;
	logic         irc_req, irc_ack;
	logic         tmr_req, tmr_ack;
	bus_rsp_t     rom_rsp, irc_rsp, tmr_rsp;
	logic         tmr_irq;
	logic [IRQ_NUM-1:0] irc_irq;

	// factor 0 is the timer, then the external lines
	assign irc_irq = {irq_ext_i, tmr_irq};

	soc_addr_decoder dec0 (
		.clk       (clk),
		.reset     (reset),
		.bus_req_i (bus_req_i),
		.bus_cmd_i (bus_cmd_i),
		.bus_ack_o (bus_ack_o),
		.bus_rsp_o (bus_rsp_o),
		.rom_req_o (rom_req),
		.rom_ack_i (rom_ack),
		.rom_rsp_i (rom_rsp),
		.irc_req_o (irc_req),
		.irc_ack_i (irc_ack),
		.irc_rsp_i (irc_rsp),
		.tmr_req_o (tmr_req),
		.tmr_ack_i (tmr_ack),
		.tmr_rsp_i (tmr_rsp)
	);

	soc_boot_rom rom0 (
		.clk   (clk),
		.reset (reset),
		.req_i (rom_req),
		.cmd_i (bus_cmd_i),
		.ack_o (rom_ack),
		.rsp_o (rom_rsp)
	);

	soc_irc irc0 (
		.clk           (clk),
		.reset         (reset),
		.req_i         (irc_req),
		.cmd_i         (bus_cmd_i),
		.ack_o         (irc_ack),
		.rsp_o         (irc_rsp),
		.irq_i         (irc_irq),
		.cpu_irq_o     (cpu_irq_o),
		.cpu_irq_ack_i (cpu_irq_ack_i)
	);

	soc_timer tmr0 (
		.clk   (clk),
		.reset (reset),
		.req_i (tmr_req),
		.cmd_i (bus_cmd_i),
		.ack_o (tmr_ack),
		.rsp_o (tmr_rsp),
		.irq_o (tmr_irq)
	);

endmodule

/* sim/tb_clk_gen.sv */
/*
 * testbench clock and reset, 4 ns period.
 * reset is high for the first 3 rising edges and drops on a falling edge.
 */

`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic reset_o
);
	localparam int HALF_PERIOD_NS = 2;

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD_NS clk_o = ~clk_o;
	end

	initial begin
		reset_o = 1'b1;
		repeat (3) @(posedge clk_o);
		@(negedge clk_o);
		reset_o = 1'b0;
	end

endmodule

/* sim/tb_soc_periph.sv */
/*
 * directed tests for soc_periph_top over the four-phase bus.
 * the binary must run with verilog/ as working directory so the rom finds boot_rom.hex.
 * inputs change and outputs are sampled on falling edges.
 */

`timescale 1ns/1ps

module tb_soc_periph;
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;

	// the five tests need roughly 600 cycles
	localparam int          CYCLE_LIMIT   = 4000;
	localparam logic [15:0] LFSR_SEED     = 16'd17836;
	localparam logic [15:0] LFSR_TAPS     = 16'hB400;
	localparam logic [31:0] ROM_BASE_WORD = 32'hB007_0000;
	localparam logic [7:0]  MAP_UNUSED    = 8'h42;

	logic                    clk;
	logic                    reset;
	logic                    bus_req;
	bus_cmd_t                bus_cmd;
	logic                    bus_ack;
	bus_rsp_t                bus_rsp;
	logic [1:0]              irq_ext;
	logic                    cpu_irq;
	logic                    cpu_irq_ack;
	logic [15:0]             lfsr_state;
	logic [IRQ_ID_WIDTH-1:0] last_id;
	int                      cycle_cnt = 0;
	int                      rsp_errors;
	int                      irq_errors;

	tb_clk_gen clk_gen0 (
		.clk_o   (clk),
		.reset_o (reset)
	);

	soc_periph_top dut0 (
		.clk           (clk),
		.reset         (reset),
		.bus_req_i     (bus_req),
		.bus_cmd_i     (bus_cmd),
		.bus_ack_o     (bus_ack),
		.bus_rsp_o     (bus_rsp),
		.irq_ext_i     (irq_ext),
		.cpu_irq_o     (cpu_irq),
		.cpu_irq_ack_i (cpu_irq_ack)
	);

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: tests still running after %0d clock cycles", CYCLE_LIMIT);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	task automatic draw_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			value      = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic [BUS_ADDR_WIDTH-1:0] reg_addr(input logic [7:0] map,
			input logic [1:0] offset);
		return {map, {(BUS_ADDR_WIDTH-10){1'b0}}, offset};
	endfunction

	function automatic bus_rsp_t word_rsp(input logic [31:0] w);
		bus_rsp_t r;
		r.rdata = w;
		return r;
	endfunction

	// ACTIVE holds the id in bits 1:0 and the flag in bit 8
	function automatic bus_rsp_t active_word(input logic [IRQ_ID_WIDTH-1:0] id,
			input logic flag);
		bus_rsp_t r;
		r.rdata                   = '0;
		r.rdata[8]                = flag;
		r.rdata[IRQ_ID_WIDTH-1:0] = id;
		return r;
	endfunction

	// reference arbitration with the active flag clear
	function automatic logic pick_winner(input logic [IRQ_NUM-1:0] req,
			input logic [IRQ_NUM-1:0] en, input logic [IRQ_NUM*PRIO_WIDTH-1:0] prio,
			input logic [PRIO_WIDTH-1:0] mask, output logic [IRQ_ID_WIDTH-1:0] id);
		logic                  found;
		logic [PRIO_WIDTH-1:0] best;
		logic [PRIO_WIDTH-1:0] p;
		found = 1'b0;
		best  = '0;
		id    = '0;
		// scanning downward lets an equal priority move to the lower index
		for (int i = IRQ_NUM-1; i >= 0; i--) begin
			p = prio[i*PRIO_WIDTH +: PRIO_WIDTH];
			if (req[i] && en[i] && p > mask && (!found || p >= best)) begin
				found = 1'b1;
				best  = p;
				id    = IRQ_ID_WIDTH'(i);
			end
		end
		return found;
	endfunction

	task automatic run_handshake(input logic [BUS_ADDR_WIDTH-1:0] addr, input logic we,
			input logic [31:0] wdata, output bus_rsp_t rsp);
		@(negedge clk);
		bus_cmd.addr  = addr;
		bus_cmd.we    = we;
		bus_cmd.wdata = wdata;
		bus_req       = 1'b1;
		@(negedge clk);
		while (bus_ack !== 1'b1) @(negedge clk);
		rsp     = bus_rsp;
		bus_req = 1'b0;
		@(negedge clk);
		while (bus_ack !== 1'b0) @(negedge clk);
	endtask

	task automatic bus_write(input logic [BUS_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
		bus_rsp_t ignored;
		run_handshake(addr, 1'b1, data, ignored);
	endtask

	task automatic bus_read(input logic [BUS_ADDR_WIDTH-1:0] addr, output bus_rsp_t rsp);
		run_handshake(addr, 1'b0, 32'd0, rsp);
	endtask

	task automatic wait_cpu_irq(input int max_cycles);
		int n;
		n = 0;
		while (cpu_irq !== 1'b1 && n < max_cycles) begin
			@(negedge clk);
			n++;
		end
	endtask

	task automatic cpu_acknowledge();
		@(negedge clk);
		cpu_irq_ack = 1'b1;
		@(negedge clk);
		while (cpu_irq !== 1'b0) @(negedge clk);
		cpu_irq_ack = 1'b0;
	endtask

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------
	task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input string what);
		if (got !== exp) begin
			rsp_errors++;
			$display("[ERROR] %0d ns: %s read 0x%08h, expected 0x%08h",
				$time, what, got.rdata, exp.rdata);
		end
	endtask

	task automatic check_irq(input logic got_irq, input logic exp_irq,
			input bus_rsp_t got_active, input bus_rsp_t exp_active, input string what);
		if (got_irq !== exp_irq) begin
			irq_errors++;
			$display("[ERROR] %0d ns: %s cpu_irq_o is %b, expected %b",
				$time, what, got_irq, exp_irq);
		end
		if (got_active !== exp_active) begin
			irq_errors++;
			$display("[ERROR] %0d ns: %s ACTIVE reads 0x%08h, expected 0x%08h",
				$time, what, got_active.rdata, exp_active.rdata);
		end
	endtask

	// ------------------------------------------------------------
	// tests
	// ------------------------------------------------------------
	task automatic test_rom();
		logic [31:0]               bits;
		logic [BUS_ADDR_WIDTH-1:0] addr;
		bus_rsp_t                  rsp;
		for (int i = 0; i < 20; i++) begin
			draw_bits(MAP_LSB, bits);
			addr = {MAP_ROM, bits[MAP_LSB-1:0]};
			bus_read(addr, rsp);
			check_rsp(rsp, word_rsp(ROM_BASE_WORD + 32'(addr[3:0])),
				$sformatf("rom word 0x%08h", addr));
		end
		bus_write(reg_addr(MAP_ROM, 2'd3), 32'hDEAD_BEEF);
		bus_read(reg_addr(MAP_ROM, 2'd3), rsp);
		check_rsp(rsp, word_rsp(ROM_BASE_WORD + 32'd3), "rom after write");
	endtask

	task automatic test_unmapped();
		bus_rsp_t rsp;
		bus_write(reg_addr(MAP_UNUSED, 2'd1), 32'h1234_5678);
		bus_read(reg_addr(MAP_UNUSED, 2'd1), rsp);
		check_rsp(rsp, word_rsp(32'd0), "unmapped 0x42");
		bus_read({8'hFF, 22'h3F_FFFF}, rsp);
		check_rsp(rsp, word_rsp(32'd0), "unmapped 0xff");
	endtask

	task automatic test_timer();
		bus_rsp_t rsp;
		int       start;
		bus_write(reg_addr(MAP_TIMER, TIMER_REG_COMPARE), 32'd50);
		bus_write(reg_addr(MAP_TIMER, TIMER_REG_COUNTER), 32'd7);
		bus_read(reg_addr(MAP_TIMER, TIMER_REG_COMPARE), rsp);
		check_rsp(rsp, word_rsp(32'd50), "timer COMPARE");
		bus_read(reg_addr(MAP_TIMER, TIMER_REG_COUNTER), rsp);
		check_rsp(rsp, word_rsp(32'd7), "timer COUNTER while disabled");
		bus_write(reg_addr(MAP_TIMER, TIMER_REG_COUNTER), 32'd0);

		// expiry needs 51 counter steps, the window opens before enabling
		start = cycle_cnt;
		bus_write(reg_addr(MAP_TIMER, TIMER_REG_CTRL), 32'd1);
		bus_read(reg_addr(MAP_TIMER, TIMER_REG_CTRL), rsp);
		check_rsp(rsp, word_rsp(32'd1), "timer CTRL");
		bus_read(reg_addr(MAP_TIMER, TIMER_REG_STATUS), rsp);
		while (rsp.rdata[0] !== 1'b1 && cycle_cnt - start < 60) begin
			bus_read(reg_addr(MAP_TIMER, TIMER_REG_STATUS), rsp);
		end
		check_rsp(rsp, word_rsp(32'd1), "timer STATUS within 60 cycles");
		bus_write(reg_addr(MAP_TIMER, TIMER_REG_STATUS), 32'd1);
		bus_read(reg_addr(MAP_TIMER, TIMER_REG_STATUS), rsp);
		check_rsp(rsp, word_rsp(32'd0), "timer STATUS after clear");
		bus_write(reg_addr(MAP_TIMER, TIMER_REG_CTRL), 32'd0);
	endtask

	task automatic test_timer_irq();
		bus_rsp_t rsp;
		bus_write(reg_addr(MAP_IRC, IRC_REG_PRIO), 32'd2);
		bus_write(reg_addr(MAP_IRC, IRC_REG_MASK), 32'd0);
		bus_write(reg_addr(MAP_IRC, IRC_REG_ENABLE), 32'd1);
		bus_write(reg_addr(MAP_TIMER, TIMER_REG_COUNTER), 32'd0);
		bus_write(reg_addr(MAP_TIMER, TIMER_REG_COMPARE), 32'd10);
		bus_write(reg_addr(MAP_TIMER, TIMER_REG_STATUS), 32'd1);
		bus_write(reg_addr(MAP_TIMER, TIMER_REG_CTRL), 32'd3);
		wait_cpu_irq(40);
		bus_read(reg_addr(MAP_IRC, IRC_REG_ACTIVE), rsp);
		check_irq(cpu_irq, 1'b1, rsp, active_word(last_id, 1'b0), "timer irq request");
		cpu_acknowledge();
		bus_read(reg_addr(MAP_IRC, IRC_REG_ACTIVE), rsp);
		check_irq(cpu_irq, 1'b0, rsp, active_word(2'd0, 1'b1), "timer irq acknowledged");
		last_id = 2'd0;

		// quiet the timer before ending the interrupt
		bus_write(reg_addr(MAP_TIMER, TIMER_REG_CTRL), 32'd0);
		bus_write(reg_addr(MAP_TIMER, TIMER_REG_STATUS), 32'd1);
		bus_write(reg_addr(MAP_IRC, IRC_REG_ACTIVE), 32'd0);
		bus_read(reg_addr(MAP_IRC, IRC_REG_ACTIVE), rsp);
		check_irq(cpu_irq, 1'b0, rsp, active_word(2'd0, 1'b0), "ACTIVE cleared");
	endtask

	task automatic test_arbitration();
		logic [IRQ_NUM*PRIO_WIDTH-1:0] prio_tab [4];
		logic [PRIO_WIDTH-1:0]         mask_tab [4];
		logic [31:0]                   bits;
		logic [IRQ_ID_WIDTH-1:0]       exp_id;
		logic                          exp_found;
		bus_rsp_t                      rsp;
		int                            k;
		// priorities packed as {f2, f1, f0}
		prio_tab[0] = {2'd1, 2'd2, 2'd3};
		mask_tab[0] = 2'd0;
		prio_tab[1] = {2'd3, 2'd3, 2'd1};
		mask_tab[1] = 2'd0;
		prio_tab[2] = {2'd3, 2'd1, 2'd2};
		mask_tab[2] = 2'd1;
		prio_tab[3] = {2'd1, 2'd1, 2'd0};
		mask_tab[3] = 2'd1;
		bus_write(reg_addr(MAP_IRC, IRC_REG_ENABLE), 32'd7);
		for (int r = 0; r < 12; r++) begin
			k = r % 4;
			bus_write(reg_addr(MAP_IRC, IRC_REG_PRIO), 32'(prio_tab[k]));
			bus_write(reg_addr(MAP_IRC, IRC_REG_MASK), 32'(mask_tab[k]));
			draw_bits(2, bits);
			@(negedge clk);
			irq_ext   = bits[1:0];
			exp_found = pick_winner({bits[1:0], 1'b0}, '1, prio_tab[k], mask_tab[k], exp_id);
			if (exp_found) begin
				wait_cpu_irq(8);
				bus_read(reg_addr(MAP_IRC, IRC_REG_ACTIVE), rsp);
				check_irq(cpu_irq, 1'b1, rsp, active_word(last_id, 1'b0), "arbitration request");
				cpu_acknowledge();
				bus_read(reg_addr(MAP_IRC, IRC_REG_ACTIVE), rsp);
				check_irq(cpu_irq, 1'b0, rsp, active_word(exp_id, 1'b1), "arbitration winner");
				last_id = exp_id;
			end else begin
				repeat (4) @(negedge clk);
				bus_read(reg_addr(MAP_IRC, IRC_REG_ACTIVE), rsp);
				check_irq(cpu_irq, 1'b0, rsp, active_word(last_id, 1'b0), "no eligible factor");
			end
			@(negedge clk);
			irq_ext = 2'b00;
			bus_write(reg_addr(MAP_IRC, IRC_REG_ACTIVE), 32'd0);
		end
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		bus_req     = 1'b0;
		bus_cmd     = '0;
		irq_ext     = '0;
		cpu_irq_ack = 1'b0;
		lfsr_state  = LFSR_SEED;
		last_id     = '0;
		rsp_errors  = 0;
		irq_errors  = 0;
		@(negedge clk);
		while (reset !== 1'b0) @(negedge clk);

		test_rom();
		test_unmapped();
		test_timer();
		test_timer_irq();
		test_arbitration();

		$display("tests done: %0d response errors, %0d interrupt errors",
			rsp_errors, irq_errors);
		if (rsp_errors + irq_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* verilog/boot_rom.hex */
// one 32-bit word per line, word n holds b0070000 plus n
B0070000
B0070001
B0070002
B0070003
B0070004
B0070005
B0070006
B0070007
B0070008
B0070009
B007000A
B007000B
B007000C
B007000D
B007000E
B007000F

/* soc_periph.f */
verilog/soc_bus_pkg.sv
verilog/soc_periph_pkg.sv
verilog/soc_addr_decoder.sv
verilog/soc_boot_rom.sv
verilog/soc_irc.sv
verilog/soc_timer.sv
verilog/soc_periph_top.sv
sim/tb_clk_gen.sv
sim/tb_soc_periph.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from verilog/,
# where the boot rom finds boot_rom.hex
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_soc_periph -f soc_periph.f

out=$(cd verilog && ../obj_dir/Vtb_soc_periph)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
